//--- Bender.yml
package:
  name: uart_apb

sources:
  - common/uart_cfg_pkg.sv
  - common/uart_reg_pkg.sv
  - uart_rx/uart_rx.sv
  - uart_tx/uart_tx.sv
  - src/uart_fifo.sv
  - src/uart_apb_regs.sv
  - src/uart_top.sv
  - target: test
    files:
      - testbench/tb_clkgen.sv
      - testbench/tb_uart_top.sv

//--- common/uart_cfg_pkg.sv
package uart_cfg_pkg;

    // width of every data byte on both sides of the link
    localparam int MAX_DATA_BITS = 8;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        EVEN = 2'd1,
        ODD  = 2'd2
    } parity_e;

    typedef enum logic [1:0] {
        ONE      = 2'd0,
        TWO      = 2'd1,
        ONE_HALF = 2'd2  // prescale x 12 cycles on the line
    } stop_e;

    // line settings shared by tx, rx and the register block
    typedef struct packed {
        logic [3:0]  data_bits;  // 5 to 8
        parity_e     parity;
        stop_e       stop;
        logic [15:0] prescale;   // bit period is prescale x 8 cycles
    } line_cfg_t;

endpackage

//--- common/uart_reg_pkg.sv
package uart_reg_pkg;

    localparam logic [4:0] REG_CTRL     = 5'h00;
    localparam logic [4:0] REG_PRESCALE = 5'h04;
    localparam logic [4:0] REG_TXDATA   = 5'h08;
    localparam logic [4:0] REG_RXDATA   = 5'h0C;
    localparam logic [4:0] REG_STATUS   = 5'h10;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // STATUS register, bit 0 is tx_full
    typedef struct packed {
        logic rsvd;
        logic overrun;    // sticky, write 1 to clear
        logic frame_err;  // sticky, write 1 to clear
        logic rx_busy;
        logic tx_busy;
        logic rx_empty;
        logic tx_empty;
        logic tx_full;
    } status_t;

endpackage

//--- files.f
common/uart_cfg_pkg.sv
common/uart_reg_pkg.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
src/uart_fifo.sv
src/uart_apb_regs.sv
src/uart_top.sv
testbench/tb_clkgen.sv
testbench/tb_uart_top.sv

//--- src/uart_apb_regs.sv
`timescale 1ns/1ps

module uart_apb_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    input  uart_reg_pkg::apb_req_t                 apb_req,
    output uart_reg_pkg::apb_rsp_t                 apb_rsp,
    output uart_cfg_pkg::line_cfg_t                cfg,
    output logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] tx_in_data,
    output logic                                   tx_in_valid,
    input  logic                                   tx_in_ready,
    input  logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] rx_out_data,
    input  logic                                   rx_out_valid,
    output logic                                   rx_out_ready,
    input  logic                                   tx_full,
    input  logic                                   tx_empty,
    input  logic                                   rx_empty,
    input  logic                                   tx_busy,
    input  logic                                   rx_busy,
    input  logic                                   frame_err,
    input  logic                                   overrun
);

    logic                  access;
    logic                  wr;
    logic                  rd;
    logic                  addr_ok;
    logic                  frame_err_q;
    logic                  overrun_q;
    uart_reg_pkg::status_t status;
    uart_reg_pkg::status_t wr_status;

    assign access    = apb_req.psel && apb_req.penable;
    assign wr        = access && apb_req.pwrite;
    assign rd        = access && !apb_req.pwrite;
    assign wr_status = apb_req.pwdata[7:0];

    assign addr_ok = apb_req.paddr inside {uart_reg_pkg::REG_CTRL, uart_reg_pkg::REG_PRESCALE,
                                           uart_reg_pkg::REG_TXDATA, uart_reg_pkg::REG_RXDATA,
                                           uart_reg_pkg::REG_STATUS};

    assign status = '{rsvd: 1'b0, overrun: overrun_q, frame_err: frame_err_q,
                      rx_busy: rx_busy, tx_busy: tx_busy, rx_empty: rx_empty,
                      tx_empty: tx_empty, tx_full: tx_full};

    // pop in the access cycle, the byte is on prdata at the same time
    assign rx_out_ready = rd && (apb_req.paddr == uart_reg_pkg::REG_RXDATA);

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && (!addr_ok
            || (wr && apb_req.paddr == uart_reg_pkg::REG_TXDATA && !tx_in_ready)
            || (rd && apb_req.paddr == uart_reg_pkg::REG_RXDATA && !rx_out_valid));
        case (apb_req.paddr)
            uart_reg_pkg::REG_CTRL:     apb_rsp.prdata = {24'd0, cfg.stop, cfg.parity,
                                                          cfg.data_bits};
            uart_reg_pkg::REG_PRESCALE: apb_rsp.prdata = {16'd0, cfg.prescale};
            uart_reg_pkg::REG_RXDATA:   apb_rsp.prdata = {24'd0, rx_out_data};
            uart_reg_pkg::REG_STATUS:   apb_rsp.prdata = {24'd0, status};
            default:                    apb_rsp.prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg         <= '{data_bits: 4'd8, parity: uart_cfg_pkg::NONE,
                             stop: uart_cfg_pkg::ONE, prescale: 16'd1};
            tx_in_valid <= 1'b0;
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
        end else begin
            tx_in_valid <= 1'b0;  // one-cycle push
            if (wr && apb_req.paddr == uart_reg_pkg::REG_CTRL) begin
                cfg.data_bits <= apb_req.pwdata[3:0];
                cfg.parity    <= uart_cfg_pkg::parity_e'(apb_req.pwdata[5:4]);
                cfg.stop      <= uart_cfg_pkg::stop_e'(apb_req.pwdata[7:6]);
            end
            if (wr && apb_req.paddr == uart_reg_pkg::REG_PRESCALE) begin
                cfg.prescale <= apb_req.pwdata[15:0];
            end
            if (wr && apb_req.paddr == uart_reg_pkg::REG_TXDATA && tx_in_ready) begin
                tx_in_valid <= 1'b1;
            end
            // a new pulse wins over a clear in the same cycle
            if (wr && apb_req.paddr == uart_reg_pkg::REG_STATUS) begin
                frame_err_q <= (frame_err_q && !wr_status.frame_err) || frame_err;
                overrun_q   <= (overrun_q && !wr_status.overrun) || overrun;
            end else begin
                frame_err_q <= frame_err_q || frame_err;
                overrun_q   <= overrun_q || overrun;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && apb_req.paddr == uart_reg_pkg::REG_TXDATA) begin
            tx_in_data <= apb_req.pwdata[7:0];
        end
    end

    assert property (@(posedge clk) disable iff (rst) apb_req.penable |-> apb_req.psel);

endmodule

//--- src/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] in_data,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    output logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] out_data,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic                                   empty,
    output logic                                   full
);

    localparam int AW = $clog2(DEPTH);

    logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] mem [DEPTH];
    logic [AW-1:0]                          wr_ptr;
    logic [AW-1:0]                          rd_ptr;
    logic [AW:0]                            count;
    logic                                   push;
    logic                                   pop;

    assign full      = (count == (AW+1)'(DEPTH));
    assign empty     = (count == '0);
    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) count <= (AW+1)'(DEPTH));

endmodule

//--- src/uart_top.sv
`timescale 1ns/1ps

module uart_top #(
    parameter int TX_DEPTH = 4,
    parameter int RX_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_reg_pkg::apb_req_t apb_req,
    output uart_reg_pkg::apb_rsp_t apb_rsp,
    input  logic                   rxd,
    output logic                   txd
);

    uart_cfg_pkg::line_cfg_t                cfg;
    logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] tx_in_data;
    logic                                   tx_in_valid;
    logic                                   tx_in_ready;
    logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] tx_data;
    logic                                   tx_valid;
    logic                                   tx_ready;
    logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] rx_data;
    logic                                   rx_valid;
    logic                                   rx_ready;
    logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] rx_out_data;
    logic                                   rx_out_valid;
    logic                                   rx_out_ready;
    logic                                   tx_full;
    logic                                   tx_empty;
    logic                                   rx_empty;
    logic                                   tx_busy;
    logic                                   rx_busy;
    logic                                   frame_err;
    logic                                   overrun;

    uart_apb_regs u_regs (
        .clk, .rst, .apb_req, .apb_rsp, .cfg,
        .tx_in_data, .tx_in_valid, .tx_in_ready,
        .rx_out_data, .rx_out_valid, .rx_out_ready,
        .tx_full, .tx_empty, .rx_empty, .tx_busy, .rx_busy, .frame_err, .overrun
    );

    uart_fifo #(.DEPTH(TX_DEPTH)) u_tx_fifo (
        .clk, .rst,
        .in_data (tx_in_data), .in_valid (tx_in_valid), .in_ready (tx_in_ready),
        .out_data (tx_data), .out_valid (tx_valid), .out_ready (tx_ready),
        .empty (tx_empty), .full (tx_full)
    );

    // rx side fullness shows up as back-pressure on uart_rx only
    uart_fifo #(.DEPTH(RX_DEPTH)) u_rx_fifo (
        .clk, .rst,
        .in_data (rx_data), .in_valid (rx_valid), .in_ready (rx_ready),
        .out_data (rx_out_data), .out_valid (rx_out_valid), .out_ready (rx_out_ready),
        .empty (rx_empty), .full ()
    );

    uart_tx u_tx (
        .clk, .rst, .cfg, .tx_data, .tx_valid, .tx_ready, .txd, .tx_busy
    );

    uart_rx u_rx (
        .clk, .rst, .rxd, .cfg, .rx_data, .rx_valid, .rx_ready,
        .rx_busy, .frame_err, .overrun
    );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- testbench/tb_uart_top.sv
`timescale 1ns/1ps

module tb_uart_top;

    localparam int TX_DEPTH     = 4;
    localparam int RX_DEPTH     = 8;
    localparam int POLL_LIMIT   = 10000;
    localparam int WAIT_RX_BYTE = 0;
    localparam int WAIT_IDLE    = 1;
    localparam int WAIT_RX_IDLE = 2;
    localparam int ERR_NONE     = 0;
    localparam int ERR_STOP     = 1;
    localparam int ERR_PARITY   = 2;

    logic                   clk;
    logic                   rst;
    uart_reg_pkg::apb_req_t apb_req;
    uart_reg_pkg::apb_rsp_t apb_rsp;
    logic                   rxd;
    logic                   txd;
    logic                   use_loop;  // 1 feeds txd back into rxd
    logic                   bb_line;
    logic [7:0]             exp_q [$];
    logic [7:0]             got_q [$];
    event                   got_ev;
    int                     n_cmp;

    assign rxd = use_loop ? txd : bb_line;

    tb_clkgen u_clkgen (.clk(clk), .rst(rst));

    uart_top #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) uut (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp), .rxd(rxd), .txd(txd)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("Fail %s: expected 0x%0h, actual 0x%0h",
                                      name, expected, actual));
        end
    endtask

    // expected byte masked to data_bits in [7:0] and its parity bit in [8]
    function automatic logic [8:0] frame_bits(input logic [7:0] b,
                                              input uart_cfg_pkg::line_cfg_t c);
        logic [7:0] d;
        logic       p;
        d = b & (8'hFF >> (8 - c.data_bits));
        p = ^d;  // even parity makes the count of ones even
        if (c.parity == uart_cfg_pkg::ODD) begin
            p = ~p;
        end else if (c.parity == uart_cfg_pkg::NONE) begin
            p = 1'b0;
        end
        return {p, d};
    endfunction

    // each APB task starts and ends on a falling edge
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;
        err = apb_rsp.pslverr;
        check_value("write pready", 1, apb_rsp.pready);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;  // mid access cycle
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        check_value("read pready", 1, apb_rsp.pready);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic set_line(input uart_cfg_pkg::line_cfg_t c);
        logic err;
        write_reg(uart_reg_pkg::REG_CTRL, {24'd0, c.stop, c.parity, c.data_bits}, err);
        check_value("ctrl write pslverr", 0, err);
        write_reg(uart_reg_pkg::REG_PRESCALE, {16'd0, c.prescale}, err);
        check_value("prescale write pslverr", 0, err);
    endtask

    task automatic poll_status(input int cond, input string what);
        uart_reg_pkg::status_t st;
        logic [31:0]           rd;
        logic                  err;
        logic                  done;
        int                    n;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            if (n == POLL_LIMIT) stop_with_error({"timeout waiting for ", what});
            read_reg(uart_reg_pkg::REG_STATUS, rd, err);
            st = rd[7:0];
            case (cond)
                WAIT_RX_BYTE: done = !st.rx_empty;
                WAIT_IDLE:    done = st.tx_empty && !st.tx_busy && !st.rx_busy;
                default:      done = !st.rx_busy;
            endcase
            n++;
        end
    endtask

    // bit-banged frame on bb_line followed by one idle bit
    task automatic send_frame(input logic [7:0] b, input uart_cfg_pkg::line_cfg_t c,
                              input int err_kind);
        logic [8:0] fb;
        int         bit_cycles;
        fb         = frame_bits(b, c);
        bit_cycles = 8 * c.prescale;
        bb_line    = 1'b0;
        repeat (bit_cycles) @(negedge clk);
        for (int i = 0; i < c.data_bits; i++) begin
            bb_line = b[i];
            repeat (bit_cycles) @(negedge clk);
        end
        if (c.parity != uart_cfg_pkg::NONE) begin
            bb_line = fb[8] ^ (err_kind == ERR_PARITY);
            repeat (bit_cycles) @(negedge clk);
        end
        bb_line = (err_kind != ERR_STOP);
        repeat (bit_cycles) @(negedge clk);
        bb_line = 1'b1;
        if (c.stop == uart_cfg_pkg::TWO) repeat (bit_cycles) @(negedge clk);
        if (c.stop == uart_cfg_pkg::ONE_HALF) repeat (bit_cycles / 2) @(negedge clk);
        repeat (bit_cycles) @(negedge clk);
    endtask

    // samples txd half a cycle after each bit centre
    task automatic sample_tx_frame(input logic [7:0] b, input uart_cfg_pkg::line_cfg_t c);
        logic [8:0] fb;
        logic       err;
        int         bit_cycles;
        int         n;
        fb         = frame_bits(b, c);
        bit_cycles = 8 * c.prescale;
        write_reg(uart_reg_pkg::REG_TXDATA, {24'd0, b}, err);
        check_value("tx frame txdata pslverr", 0, err);
        n = 0;
        while (txd !== 1'b0) begin
            if (n == 3) stop_with_error("start bit did not appear after a TXDATA write");
            @(negedge clk);
            n++;
        end
        repeat (bit_cycles / 2) @(negedge clk);
        check_value("tx start bit", 0, txd);
        for (int i = 0; i < c.data_bits; i++) begin
            repeat (bit_cycles) @(negedge clk);
            check_value($sformatf("tx data bit %0d", i), fb[i], txd);
        end
        if (c.parity != uart_cfg_pkg::NONE) begin
            repeat (bit_cycles) @(negedge clk);
            check_value("tx parity bit", fb[8], txd);
        end
        repeat (bit_cycles) @(negedge clk);
        check_value("tx stop bit", 1, txd);
    endtask

    // compares received bytes against the reference, in order
    always @(got_ev) begin
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            check_value($sformatf("rx byte %0d", n_cmp), exp_q.pop_front(), got_q.pop_front());
            n_cmp++;
        end
    end

    initial begin
        logic [31:0]             rd;
        logic                    err;
        logic [7:0]              b;
        logic [8:0]              fb;
        logic [7:0]              sent [RX_DEPTH+2];
        uart_cfg_pkg::line_cfg_t c;
        uart_reg_pkg::status_t   st;
        int                      n;
        apb_req  = '0;
        use_loop = 1'b0;
        bb_line  = 1'b1;
        n_cmp    = 0;
        void'($urandom(32'h552a));
        n = 0;
        while (rst) begin
            @(negedge clk);
            n++;
            if (n > 10) stop_with_error("reset was never released");
        end
        @(negedge clk);

        // register access
        check_value("txd idle after reset", 1, txd);
        read_reg(uart_reg_pkg::REG_STATUS, rd, err);
        st          = '0;
        st.tx_empty = 1'b1;
        st.rx_empty = 1'b1;
        check_value("status after reset", st, rd);
        write_reg(uart_reg_pkg::REG_CTRL, 32'h67, err);  // 7 bits, odd, two stops
        read_reg(uart_reg_pkg::REG_CTRL, rd, err);
        check_value("ctrl readback", 32'h67, rd);
        write_reg(uart_reg_pkg::REG_PRESCALE, 32'h1234, err);
        read_reg(uart_reg_pkg::REG_PRESCALE, rd, err);
        check_value("prescale readback", 32'h1234, rd);
        read_reg(5'h14, rd, err);
        check_value("unmapped read pslverr", 1, err);

        // loopback over every line setting
        use_loop = 1'b1;
        for (int db = 5; db <= 8; db++) begin
            for (int p = 0; p < 3; p++) begin
                for (int s = 0; s < 3; s++) begin
                    c.data_bits = 4'(db);
                    c.parity    = uart_cfg_pkg::parity_e'(p);
                    c.stop      = uart_cfg_pkg::stop_e'(s);
                    c.prescale  = 16'd2;
                    set_line(c);
                    repeat (20) begin
                        b  = 8'($urandom());
                        fb = frame_bits(b, c);
                        exp_q.push_back(fb[7:0]);
                        write_reg(uart_reg_pkg::REG_TXDATA, {24'd0, b}, err);
                        check_value("loopback txdata pslverr", 0, err);
                        poll_status(WAIT_RX_BYTE, "a looped-back byte");
                        read_reg(uart_reg_pkg::REG_RXDATA, rd, err);
                        got_q.push_back(rd[7:0]);
                        ->got_ev;
                    end
                    poll_status(WAIT_IDLE, "tx and rx to go idle");
                end
            end
        end
        use_loop = 1'b0;

        // transmit framing for 8N1, 8E1 and 8O1
        for (int p = 0; p < 3; p++) begin
            c = '{data_bits: 4'd8, parity: uart_cfg_pkg::parity_e'(p),
                  stop: uart_cfg_pkg::ONE, prescale: 16'd2};
            set_line(c);
            sample_tx_frame(8'($urandom()), c);
            poll_status(WAIT_IDLE, "the transmitter to finish");
        end

        // low stop bit, then flipped parity bit
        c = '{data_bits: 4'd8, parity: uart_cfg_pkg::EVEN, stop: uart_cfg_pkg::ONE,
              prescale: 16'd2};
        set_line(c);
        for (int k = ERR_STOP; k <= ERR_PARITY; k++) begin
            send_frame(8'($urandom()), c, k);
            poll_status(WAIT_RX_IDLE, "the receiver to finish a bad frame");
            read_reg(uart_reg_pkg::REG_STATUS, rd, err);
            st = rd[7:0];
            check_value($sformatf("frame_err set, case %0d", k), 1, st.frame_err);
            check_value($sformatf("rx_empty after bad frame, case %0d", k), 1, st.rx_empty);
            read_reg(uart_reg_pkg::REG_RXDATA, rd, err);
            check_value("empty rxdata read pslverr", 1, err);
            st           = '0;
            st.frame_err = 1'b1;
            write_reg(uart_reg_pkg::REG_STATUS, {24'd0, st}, err);
            read_reg(uart_reg_pkg::REG_STATUS, rd, err);
            st = rd[7:0];
            check_value("frame_err cleared", 0, st.frame_err);
        end

        // overrun with the rx FIFO full
        c.parity = uart_cfg_pkg::NONE;
        set_line(c);
        for (int i = 0; i < RX_DEPTH + 2; i++) begin
            sent[i] = 8'($urandom());
            send_frame(sent[i], c, ERR_NONE);
        end
        poll_status(WAIT_RX_IDLE, "the receiver after the overrun burst");
        read_reg(uart_reg_pkg::REG_STATUS, rd, err);
        st = rd[7:0];
        check_value("overrun set", 1, st.overrun);
        for (int i = 0; i < RX_DEPTH; i++) exp_q.push_back(sent[i]);
        exp_q.push_back(sent[RX_DEPTH+1]);  // pending byte was replaced by the last one
        for (int i = 0; i <= RX_DEPTH; i++) begin
            read_reg(uart_reg_pkg::REG_RXDATA, rd, err);
            check_value("rxdata read pslverr", 0, err);
            got_q.push_back(rd[7:0]);
            ->got_ev;
        end
        st         = '0;
        st.overrun = 1'b1;
        write_reg(uart_reg_pkg::REG_STATUS, {24'd0, st}, err);
        read_reg(uart_reg_pkg::REG_STATUS, rd, err);
        st = rd[7:0];
        check_value("overrun cleared", 0, st.overrun);
        check_value("rx_empty after drain", 1, st.rx_empty);

        // tx FIFO full while the transmitter is busy
        c.prescale = 16'd20;
        set_line(c);
        for (int i = 0; i < TX_DEPTH + 2; i++) begin
            write_reg(uart_reg_pkg::REG_TXDATA, 32'(i), err);
            check_value($sformatf("txdata write %0d pslverr", i), (i == TX_DEPTH + 1), err);
        end
        read_reg(uart_reg_pkg::REG_STATUS, rd, err);
        st = rd[7:0];
        check_value("tx_full", 1, st.tx_full);
        check_value("tx_busy", 1, st.tx_busy);
        poll_status(WAIT_IDLE, "the transmit FIFO to drain");

        if (got_q.size() == 0 && exp_q.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_error("number of bytes read differs from the number expected");
        end
    end

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   rxd,
    input  uart_cfg_pkg::line_cfg_t                cfg,
    output logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] rx_data,
    output logic                                   rx_valid,
    input  logic                                   rx_ready,
    output logic                                   rx_busy,
    output logic                                   frame_err,
    output logic                                   overrun
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_e;

    state_e                                 state;
    logic                                   rxd_reg;
    logic [18:0]                            cnt;
    logic [18:0]                            bit_len;
    logic [18:0]                            half_len;
    logic [18:0]                            last_stop_len;
    logic [3:0]                             bit_idx;
    logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] shreg;
    logic                                   par_acc;
    logic                                   second_stop;
    logic                                   parity_ok;

    assign bit_len  = {cfg.prescale, 3'b000} - 19'd1;
    assign half_len = {1'b0, cfg.prescale, 2'b00} - 19'd2;  // rxd register eats one cycle

    // centre of the extra stop bit, three quarters of a bit away for one and a half
    assign last_stop_len = (cfg.stop == uart_cfg_pkg::ONE_HALF)
                         ? ({1'b0, cfg.prescale, 2'b00} + {2'b00, cfg.prescale, 1'b0} - 19'd1)
                         : bit_len;

    // par_acc holds data bits xor parity bit
    assign parity_ok = (cfg.parity == uart_cfg_pkg::NONE) ||
                       (par_acc == (cfg.parity == uart_cfg_pkg::ODD));
    assign rx_busy   = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            rxd_reg     <= 1'b1;
            cnt         <= '0;
            bit_idx     <= '0;
            par_acc     <= 1'b0;
            second_stop <= 1'b0;
            rx_valid    <= 1'b0;
            frame_err   <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            rxd_reg   <= rxd;
            frame_err <= 1'b0;
            overrun   <= 1'b0;
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            if (cnt != '0) begin
                cnt <= cnt - 19'd1;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (!rxd_reg) begin
                            cnt   <= half_len;
                            state <= S_START;
                        end
                    end
                    S_START: begin
                        if (rxd_reg) begin
                            state <= S_IDLE;  // too short for a start bit
                        end else begin
                            cnt         <= bit_len;
                            bit_idx     <= '0;
                            shreg       <= '0;
                            par_acc     <= 1'b0;
                            second_stop <= (cfg.stop != uart_cfg_pkg::ONE);
                            state       <= S_DATA;
                        end
                    end
                    S_DATA: begin
                        shreg[bit_idx[2:0]] <= rxd_reg;  // lsb first, right-aligned
                        par_acc <= par_acc ^ rxd_reg;
                        bit_idx <= bit_idx + 4'd1;
                        cnt     <= bit_len;
                        if (bit_idx == cfg.data_bits - 4'd1) begin
                            state <= (cfg.parity == uart_cfg_pkg::NONE) ? S_STOP : S_PARITY;
                        end
                    end
                    S_PARITY: begin
                        par_acc <= par_acc ^ rxd_reg;
                        cnt     <= bit_len;
                        state   <= S_STOP;
                    end
                    default: begin
                        if (rxd_reg && second_stop) begin
                            second_stop <= 1'b0;
                            cnt         <= last_stop_len;
                        end else begin
                            state <= S_IDLE;
                            if (rxd_reg && parity_ok) begin
                                rx_data  <= shreg;
                                rx_valid <= 1'b1;
                                overrun  <= rx_valid && !rx_ready;  // old byte replaced
                            end else begin
                                frame_err <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // pending byte only changes when an overrun replaces it
    assert property (@(posedge clk) disable iff (rst)
        rx_valid && !rx_ready |=> $stable(rx_data) || overrun);

endmodule

//--- uart_tx/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                                   clk,
    input  logic                                   rst,
    input  uart_cfg_pkg::line_cfg_t                cfg,
    input  logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] tx_data,
    input  logic                                   tx_valid,
    output logic                                   tx_ready,
    output logic                                   txd,
    output logic                                   tx_busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_e;

    state_e                                 state;
    logic [19:0]                            cnt;
    logic [19:0]                            bit_len;
    logic [19:0]                            stop_len;
    logic [3:0]                             bit_idx;
    logic [uart_cfg_pkg::MAX_DATA_BITS-1:0] shreg;
    logic                                   par;

    assign bit_len = {1'b0, cfg.prescale, 3'b000} - 20'd1;

    always_comb begin
        case (cfg.stop)
            uart_cfg_pkg::TWO:      stop_len = {cfg.prescale, 4'b0000} - 20'd1;
            uart_cfg_pkg::ONE_HALF: stop_len = {1'b0, cfg.prescale, 3'b000}
                                             + {2'b00, cfg.prescale, 2'b00} - 20'd1;
            default:                stop_len = bit_len;
        endcase
    end

    assign tx_ready = (state == S_IDLE);
    assign tx_busy  = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            txd     <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
            par     <= 1'b0;
        end else if (cnt != '0) begin
            cnt <= cnt - 20'd1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (tx_valid) begin
                        shreg   <= tx_data;
                        par     <= (cfg.parity == uart_cfg_pkg::ODD);  // odd starts at 1
                        txd     <= 1'b0;                               // start bit
                        cnt     <= bit_len;
                        bit_idx <= '0;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (bit_idx == cfg.data_bits) begin
                        if (cfg.parity != uart_cfg_pkg::NONE) begin
                            txd   <= par;
                            cnt   <= bit_len;
                            state <= S_PARITY;
                        end else begin
                            txd   <= 1'b1;
                            cnt   <= stop_len;
                            state <= S_STOP;
                        end
                    end else begin
                        txd     <= shreg[0];
                        par     <= par ^ shreg[0];
                        shreg   <= shreg >> 1;
                        bit_idx <= bit_idx + 4'd1;
                        cnt     <= bit_len;
                    end
                end
                S_PARITY: begin
                    txd   <= 1'b1;
                    cnt   <= stop_len;
                    state <= S_STOP;
                end
                default: state <= S_IDLE;  // stop time over
            endcase
        end
    end

    // line rests high whenever no frame is on the wire
    assert property (@(posedge clk) disable iff (rst) !tx_busy |-> txd);

endmodule
